/* lsu_top.f */
source/lsu_pkg.sv
source/lsu_request_former.sv
source/lsu_request_fifo.sv
source/lsu_data_memory.sv
source/lsu_top.sv
verification/lsu_ref_model.sv
verification/lsu_tb.sv

/* run_lsu_sim.sh */
#!/bin/sh
# Builds the LSU testbench with Verilator and runs it

BUILD_DIR=obj_dir
BUILD_LOG=lsu_build.log
SIM_LOG=lsu_sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb \
    --Mdir "$BUILD_DIR" -o lsu_sim -f lsu_top.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed"
    exit 1
fi

"./$BUILD_DIR/lsu_sim" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Done: errors found" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "Done: no errors" "$SIM_LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

/* verification/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

localparam int NUM_RANDOM   = 400;
localparam int ADDR_WINDOW  = 16;    // Four words so stores and loads collide
localparam int SEED         = 45324;
localparam int DRAIN_CYCLES = 100;   // Bound on the wait for the last responses

logic                  clk;
logic                  arst_n;
lsu_pkg::lsu_uop_t     uop;
logic                  uop_valid;
logic                  uop_ready;
lsu_pkg::load_resp_t   resp;
logic                  resp_valid;
logic                  resp_ready;
logic                  misalign;

lsu_pkg::lsu_uop_t     stim_q[$];
lsu_pkg::load_resp_t   expect_q[$];   // Pending loads in acceptance order
logic                  offer_taken;
logic                  misalign_due;
int                    error_count;
int                    check_count;
int                    cycle_count;
int                    timeout_cycles;

lsu_top dut_i (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .uop_i        (uop),
    .uop_valid_i  (uop_valid),
    .uop_ready_o  (uop_ready),
    .resp_o       (resp),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .misalign_o   (misalign)
);

always #50 clk = ~clk;

always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
        $display("Timeout: run still busy after %0d cycles", cycle_count);
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        $display("Done: errors found");
        $finish;
    end
end

task automatic report_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    error_count++;
    $display("Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
endtask

task automatic report_failure(input string what);
    error_count++;
    $display("Failure: %s at %0t", what, $time);
endtask

task automatic add_uop(input lsu_pkg::mem_op_e op, input logic [lsu_pkg::ADDR_W-1:0] addr,
                       input logic [lsu_pkg::DATA_W-1:0] data,
                       input logic [lsu_pkg::TAG_W-1:0] tag);
    lsu_pkg::lsu_uop_t u;
    u.op         = op;
    u.addr       = addr;
    u.store_data = data;
    u.tag        = tag;
    stim_q.push_back(u);
endtask

task automatic build_stimulus();
    logic [31:0] op_rnd;
    logic [31:0] addr_rnd;
    logic [31:0] data_rnd;
    logic [31:0] tag_rnd;
    add_uop(lsu_pkg::OP_LW,  8'h00, 32'h0, 5'd1);          // Fresh memory reads zero
    add_uop(lsu_pkg::OP_LW,  8'h3c, 32'h0, 5'd2);
    add_uop(lsu_pkg::OP_LBU, 8'h05, 32'h0, 5'd3);
    add_uop(lsu_pkg::OP_SW,  8'h04, 32'h8421_f07f, 5'd4);
    add_uop(lsu_pkg::OP_LW,  8'h04, 32'h0, 5'd5);
    add_uop(lsu_pkg::OP_SB,  8'h05, 32'h0000_00a5, 5'd6);  // Lane merge
    add_uop(lsu_pkg::OP_SH,  8'h06, 32'h0000_9234, 5'd7);
    add_uop(lsu_pkg::OP_LW,  8'h04, 32'h0, 5'd8);
    add_uop(lsu_pkg::OP_LB,  8'h05, 32'h0, 5'd9);
    add_uop(lsu_pkg::OP_LBU, 8'h05, 32'h0, 5'd10);
    add_uop(lsu_pkg::OP_LH,  8'h06, 32'h0, 5'd11);
    add_uop(lsu_pkg::OP_LHU, 8'h06, 32'h0, 5'd12);
    add_uop(lsu_pkg::OP_LB,  8'h04, 32'h0, 5'd13);
    // Misaligned ones must leave the word alone
    add_uop(lsu_pkg::OP_LH,  8'h05, 32'h0, 5'd14);
    add_uop(lsu_pkg::OP_SW,  8'h06, 32'hffff_ffff, 5'd15);
    add_uop(lsu_pkg::OP_SH,  8'h07, 32'hffff_ffff, 5'd16);
    add_uop(lsu_pkg::OP_NOP, 8'h04, 32'hffff_ffff, 5'd17);
    add_uop(lsu_pkg::OP_LW,  8'h04, 32'h0, 5'd18);
    for (int n = 0; n < NUM_RANDOM; n++) begin
        op_rnd   = $urandom % 9;
        addr_rnd = $urandom % ADDR_WINDOW;
        data_rnd = $urandom;
        tag_rnd  = $urandom;
        add_uop(lsu_pkg::mem_op_e'(op_rnd[3:0]), addr_rnd[lsu_pkg::ADDR_W-1:0], data_rnd,
                tag_rnd[lsu_pkg::TAG_W-1:0]);
    end
endtask

// Model sees uops in the order the DUT takes them
task automatic apply_model(input lsu_pkg::lsu_uop_t u);
    lsu_pkg::load_resp_t expected;
    int                  addr;
    addr = int'(u.addr);
    if (lsu_ref_model::is_misaligned(u.op, addr)) begin
        misalign_due = 1'b1;
    end else if (lsu_ref_model::is_store(u.op)) begin
        lsu_ref_model::write_store(u.op, addr, u.store_data);
    end else if (lsu_ref_model::access_size(u.op) != 0) begin
        expected.data = lsu_ref_model::read_load(u.op, addr);
        expected.tag  = u.tag;
        expect_q.push_back(expected);
    end
endtask

task automatic check_response();
    lsu_pkg::load_resp_t expected;
    check_count++;
    assert (expect_q.size() > 0)
        else report_failure("response arrived with no load pending");
    if (expect_q.size() > 0) begin
        expected = expect_q.pop_front();
        assert (resp.data == expected.data)
            else report_mismatch("load_data", expected.data, resp.data);
        assert (resp.tag == expected.tag)
            else report_mismatch("load_tag", 32'(expected.tag), 32'(resp.tag));
    end
endtask

task automatic check_reset_state();
    check_count++;
    assert (!resp_valid) else report_mismatch("reset_resp_valid", 32'd0, 32'(resp_valid));
    assert (!misalign) else report_mismatch("reset_misalign", 32'd0, 32'(misalign));
endtask

// Each clock checks the last edge, drives at the falling edge and looks ahead to the next edge
task automatic run_cycle();
    @(negedge clk);
    check_count++;
    assert (misalign == misalign_due)
        else report_mismatch("misalign", 32'(misalign_due), 32'(misalign));
    misalign_due = 1'b0;
    if (!uop_valid || offer_taken) begin
        if (stim_q.size() > 0 && ($urandom % 10) != 0) begin
            uop       = stim_q.pop_front();
            uop_valid = 1'b1;
        end else begin
            uop_valid = 1'b0;
        end
    end
    resp_ready = ($urandom % 10) >= 3;                 // Low about 30% of the time
    #1;
    offer_taken = uop_valid && uop_ready;
    if (offer_taken) begin
        apply_model(uop);
    end
    if (resp_valid && resp_ready) begin
        check_response();
    end
endtask

initial begin
    void'($urandom(SEED));
    clk          = 1'b0;
    arst_n       = 1'b0;
    uop          = '0;
    uop_valid    = 1'b0;
    resp_ready   = 1'b0;
    offer_taken  = 1'b0;
    misalign_due = 1'b0;
    error_count  = 0;
    check_count  = 0;
    cycle_count  = 0;
    lsu_ref_model::clear_memory();
    build_stimulus();
    timeout_cycles = stim_q.size() * 10 + 100;

    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_reset_state();

    while (stim_q.size() > 0 || uop_valid) begin
        run_cycle();
    end
    // Remaining loads get a bounded number of cycles to respond
    for (int c = 0; c < DRAIN_CYCLES && expect_q.size() > 0; c++) begin
        run_cycle();
    end
    repeat (8) run_cycle();                            // Nothing extra may turn up

    check_count++;
    assert (expect_q.size() == 0) else report_failure("loads left without a response");
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
        $display("Done: no errors");
    end else begin
        $display("Done: errors found");
    end
    $finish;
end

endmodule

/* verification/lsu_ref_model.sv */
package lsu_ref_model;

// Image of the data memory, updated in acceptance order
logic [lsu_pkg::DATA_W-1:0] model_mem [lsu_pkg::MEM_WORDS];

function automatic void clear_memory();
    for (int w = 0; w < lsu_pkg::MEM_WORDS; w++) begin
        model_mem[w] = '0;
    end
endfunction

// Bytes touched by an access, zero for NOP
function automatic int access_size(input lsu_pkg::mem_op_e op);
    int size;
    size = 0;
    case (op)
        lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_SB: size = 1;
        lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: size = 2;
        lsu_pkg::OP_LW, lsu_pkg::OP_SW:                  size = 4;
        default:                                         size = 0;
    endcase
    return size;
endfunction

function automatic bit is_store(input lsu_pkg::mem_op_e op);
    return (op == lsu_pkg::OP_SB) || (op == lsu_pkg::OP_SH) || (op == lsu_pkg::OP_SW);
endfunction

// An access must start on a multiple of its own size
function automatic bit is_misaligned(input lsu_pkg::mem_op_e op, input int addr);
    int size;
    size = access_size(op);
    return (size > 1) && ((addr % size) != 0);
endfunction

function automatic void write_store(input lsu_pkg::mem_op_e op, input int addr,
                                    input logic [lsu_pkg::DATA_W-1:0] data);
    int a;
    for (int i = 0; i < access_size(op); i++) begin
        a = addr + i;                              // Byte i of data goes to address addr+i
        model_mem[a / lsu_pkg::DATA_BYTES][(a % lsu_pkg::DATA_BYTES) * 8 +: 8] = data[i*8 +: 8];
    end
endfunction

function automatic logic [lsu_pkg::DATA_W-1:0] read_load(input lsu_pkg::mem_op_e op,
                                                         input int addr);
    logic [lsu_pkg::DATA_W-1:0] value;
    int                         size;
    int                         a;
    size  = access_size(op);
    value = '0;
    for (int i = 0; i < size; i++) begin
        a = addr + i;
        value[i*8 +: 8] = model_mem[a / lsu_pkg::DATA_BYTES][(a % lsu_pkg::DATA_BYTES) * 8 +: 8];
    end
    // Sign fill only for LB and LH
    if ((op == lsu_pkg::OP_LB || op == lsu_pkg::OP_LH) && value[size*8-1]) begin
        for (int j = size * 8; j < lsu_pkg::DATA_W; j++) begin
            value[j] = 1'b1;
        end
    end
    return value;
endfunction

endpackage

/* source/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    input  lsu_pkg::lsu_uop_t    uop_i,
    input  logic                 uop_valid_i,
    output logic                 uop_ready_o,

    output lsu_pkg::load_resp_t  resp_o,
    output logic                 resp_valid_o,
    input  logic                 resp_ready_i,

    output logic                 misalign_o
);

// Former to queue
lsu_pkg::mem_req_t   formed_req;
logic                formed_valid;
logic                queue_ready;

// Queue to memory
lsu_pkg::mem_req_t   queued_req;
logic                queued_valid;
logic                mem_ready;

lsu_request_former u_former (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .uop_i        (uop_i),
    .uop_valid_i  (uop_valid_i),
    .uop_ready_o  (uop_ready_o),
    .req_o        (formed_req),
    .req_valid_o  (formed_valid),
    .req_ready_i  (queue_ready),
    .misalign_o   (misalign_o)
);

lsu_request_fifo u_fifo (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .in_i         (formed_req),
    .in_valid_i   (formed_valid),
    .in_ready_o   (queue_ready),
    .out_o        (queued_req),
    .out_valid_o  (queued_valid),
    .out_ready_i  (mem_ready)
);

// Held response back-pressures through queue to uop_ready_o
lsu_data_memory u_memory (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (queued_req),
    .req_valid_i  (queued_valid),
    .req_ready_o  (mem_ready),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i)
);

endmodule

/* source/lsu_data_memory.sv */
`timescale 1ns/1ps

module lsu_data_memory (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    input  lsu_pkg::mem_req_t    req_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,

    output lsu_pkg::load_resp_t  resp_o,
    output logic                 resp_valid_o,
    input  logic                 resp_ready_i
);

logic [lsu_pkg::DATA_W-1:0]   mem_q [lsu_pkg::MEM_WORDS];
logic [lsu_pkg::DATA_W-1:0]   rd_word;
logic                         req_accept;
logic                         is_load;
logic                         is_store;
lsu_pkg::load_resp_t          resp_d;
lsu_pkg::load_resp_t          resp_q;
logic                         resp_valid_q;

// Picks the addressed lanes and extends them to a full word
function automatic logic [lsu_pkg::DATA_W-1:0] extend_load(
    input lsu_pkg::mem_op_e              op,
    input logic [lsu_pkg::DATA_W-1:0]    word,
    input logic [lsu_pkg::OFFS_W-1:0]    offset
);
    logic [lsu_pkg::DATA_W-1:0] lanes;
    logic [lsu_pkg::DATA_W-1:0] result;
    lanes = word >> {offset, 3'b000};
    case (op)
        lsu_pkg::OP_LB:  result = {{(lsu_pkg::DATA_W-8){lanes[7]}}, lanes[7:0]};
        lsu_pkg::OP_LBU: result = {{(lsu_pkg::DATA_W-8){1'b0}}, lanes[7:0]};
        lsu_pkg::OP_LH:  result = {{(lsu_pkg::DATA_W-16){lanes[15]}}, lanes[15:0]};
        lsu_pkg::OP_LHU: result = {{(lsu_pkg::DATA_W-16){1'b0}}, lanes[15:0]};
        default:         result = word;      // LW, offset is zero
    endcase
    return result;
endfunction

always_comb begin
    is_load  = 1'b0;
    is_store = 1'b0;
    case (req_i.op)
        lsu_pkg::OP_LB, lsu_pkg::OP_LH, lsu_pkg::OP_LW,
        lsu_pkg::OP_LBU, lsu_pkg::OP_LHU: is_load  = 1'b1;
        lsu_pkg::OP_SB, lsu_pkg::OP_SH,
        lsu_pkg::OP_SW:                   is_store = 1'b1;
        default: ;
    endcase
end

// Stalls only while a load result is held downstream
assign req_ready_o = !resp_valid_q || resp_ready_i;
assign req_accept  = req_valid_i && req_ready_o;

assign rd_word     = mem_q[req_i.word_idx];
assign resp_d.data = extend_load(req_i.op, rd_word, req_i.offset);
assign resp_d.tag  = req_i.tag;

// Storage array, zero after reset
always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        for (int w = 0; w < lsu_pkg::MEM_WORDS; w++) begin
            mem_q[w] <= '0;
        end
    end else if (req_accept && is_store) begin
        for (int b = 0; b < lsu_pkg::DATA_BYTES; b++) begin
            if (req_i.byte_mask[b]) begin
                mem_q[req_i.word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
            end
        end
    end
end

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        resp_valid_q <= 1'b0;
    end else begin
        if (resp_valid_q && resp_ready_i) begin
            resp_valid_q <= 1'b0;
        end
        if (req_accept && is_load) begin
            resp_valid_q <= 1'b1;            // Stores give no response
        end
    end
end

always_ff @(posedge clk_i) begin
    if (req_accept && is_load) begin
        resp_q <= resp_d;
    end
end

assign resp_o       = resp_q;
assign resp_valid_o = resp_valid_q;

endmodule

/* source/lsu_request_fifo.sv */
`timescale 1ns/1ps

module lsu_request_fifo (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    input  lsu_pkg::mem_req_t    in_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,

    output lsu_pkg::mem_req_t    out_o,
    output logic                 out_valid_o,
    input  logic                 out_ready_i
);

lsu_pkg::mem_req_t                 entries_q [lsu_pkg::FIFO_DEPTH];
logic [lsu_pkg::FIFO_PTR_W-1:0]    wr_ptr_q;
logic [lsu_pkg::FIFO_PTR_W-1:0]    rd_ptr_q;
logic [lsu_pkg::FIFO_CNT_W-1:0]    count_q;
logic                              push;
logic                              pop;

assign in_ready_o  = (count_q != lsu_pkg::FIFO_FULL);
assign out_valid_o = (count_q != '0);

assign push = in_valid_i && in_ready_o;
assign pop  = out_valid_o && out_ready_i;

// Head entry is visible the cycle after it is written
assign out_o = entries_q[rd_ptr_q];

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
    end else begin
        if (push) begin
            wr_ptr_q <= (wr_ptr_q == lsu_pkg::FIFO_LAST) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
            rd_ptr_q <= (rd_ptr_q == lsu_pkg::FIFO_LAST) ? '0 : rd_ptr_q + 1'b1;
        end
        case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;     // Both or neither
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (push) begin
        entries_q[wr_ptr_q] <= in_i;
    end
end

endmodule

/* source/lsu_request_former.sv */
`timescale 1ns/1ps

module lsu_request_former (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    input  lsu_pkg::lsu_uop_t    uop_i,
    input  logic                 uop_valid_i,
    output logic                 uop_ready_o,

    output lsu_pkg::mem_req_t    req_o,
    output logic                 req_valid_o,
    input  logic                 req_ready_i,

    output logic                 misalign_o
);

logic [lsu_pkg::OFFS_W-1:0]      offset;
logic                            is_byte;
logic                            is_half;
logic                            is_word;
logic                            is_store;
logic                            misaligned;
logic                            uop_accept;
logic [lsu_pkg::DATA_BYTES-1:0]  byte_mask;
logic [lsu_pkg::DATA_W-1:0]      lane_data;
lsu_pkg::mem_req_t               req_d;
lsu_pkg::mem_req_t               req_q;
logic                            req_valid_q;
logic                            misalign_q;

assign offset = uop_i.addr[lsu_pkg::OFFS_W-1:0];

// Access size and direction from the opcode
always_comb begin
    is_byte  = 1'b0;
    is_half  = 1'b0;
    is_word  = 1'b0;
    is_store = 1'b0;
    case (uop_i.op)
        lsu_pkg::OP_LB, lsu_pkg::OP_LBU: is_byte = 1'b1;
        lsu_pkg::OP_LH, lsu_pkg::OP_LHU: is_half = 1'b1;
        lsu_pkg::OP_LW:                  is_word = 1'b1;
        lsu_pkg::OP_SB: begin
            is_byte  = 1'b1;
            is_store = 1'b1;
        end
        lsu_pkg::OP_SH: begin
            is_half  = 1'b1;
            is_store = 1'b1;
        end
        lsu_pkg::OP_SW: begin
            is_word  = 1'b1;
            is_store = 1'b1;
        end
        default: ;                       // NOP carries no access
    endcase
end

// Halfwords need an even address, words need offset zero
assign misaligned = (is_half && offset[0]) || (is_word && (offset != '0));

always_comb begin
    byte_mask = '0;
    if (is_byte) begin
        byte_mask = lsu_pkg::MASK_BYTE << offset;
    end else if (is_half) begin
        byte_mask = lsu_pkg::MASK_HALF << offset;
    end else if (is_word) begin
        byte_mask = lsu_pkg::MASK_WORD;
    end
end

// Eight bits per offset byte
assign lane_data = is_store ? (uop_i.store_data << {offset, 3'b000}) : '0;

assign req_d.op        = uop_i.op;
assign req_d.word_idx  = uop_i.addr[lsu_pkg::ADDR_W-1:lsu_pkg::OFFS_W];
assign req_d.offset    = offset;
assign req_d.byte_mask = byte_mask;
assign req_d.wdata     = lane_data;
assign req_d.tag       = uop_i.tag;

assign uop_ready_o = !req_valid_q || req_ready_i;
assign uop_accept  = uop_valid_i && uop_ready_o;

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        req_valid_q <= 1'b0;
        misalign_q  <= 1'b0;
    end else begin
        if (req_valid_q && req_ready_i) begin
            req_valid_q <= 1'b0;
        end
        if (uop_accept && !misaligned && (is_byte || is_half || is_word)) begin
            req_valid_q <= 1'b1;
        end
        misalign_q <= uop_accept && misaligned;  // Dropped, pulse only
    end
end

always_ff @(posedge clk_i) begin
    if (uop_accept) begin
        req_q <= req_d;
    end
end

assign req_o       = req_q;
assign req_valid_o = req_valid_q;
assign misalign_o  = misalign_q;

endmodule

/* source/lsu_pkg.sv */
package lsu_pkg;

// Word and address geometry
localparam int DATA_W     = 32;
localparam int DATA_BYTES = 4;
localparam int ADDR_W     = 8;   // 64 words of byte address space
localparam int MEM_WORDS  = 64;
localparam int FIFO_DEPTH = 4;
localparam int TAG_W      = 5;   // Destination register tag

localparam int OFFS_W     = $clog2(DATA_BYTES);
localparam int IDX_W      = ADDR_W - OFFS_W;
localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

localparam logic [FIFO_CNT_W-1:0] FIFO_FULL = FIFO_CNT_W'(FIFO_DEPTH);
localparam logic [FIFO_PTR_W-1:0] FIFO_LAST = FIFO_PTR_W'(FIFO_DEPTH - 1);

// Lane masks before shifting by the byte offset
localparam logic [DATA_BYTES-1:0] MASK_BYTE = DATA_BYTES'(1);
localparam logic [DATA_BYTES-1:0] MASK_HALF = DATA_BYTES'(3);
localparam logic [DATA_BYTES-1:0] MASK_WORD = '1;

typedef enum logic [3:0] {
    OP_NOP,
    OP_LB,
    OP_LH,
    OP_LW,
    OP_LBU,
    OP_LHU,
    OP_SB,
    OP_SH,
    OP_SW
} mem_op_e;

// Decoded micro-op as it arrives from issue
typedef struct packed {
    mem_op_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   store_data;
    logic [TAG_W-1:0]    tag;
} lsu_uop_t;

typedef struct packed {
    mem_op_e                 op;
    logic [IDX_W-1:0]        word_idx;
    logic [OFFS_W-1:0]       offset;
    logic [DATA_BYTES-1:0]   byte_mask;
    logic [DATA_W-1:0]       wdata;     // Already moved into its byte lanes
    logic [TAG_W-1:0]        tag;
} mem_req_t;

typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [TAG_W-1:0]    tag;
} load_resp_t;

endpackage
